//--- files.f
verilog/fetch_pkg.sv
verilog/cache_pkg.sv
verilog/redirect_latch.sv
verilog/icache_ctrl.sv
verilog/fetch_unit.sv
tests/tb_fetch.sv

//--- run_sim.sh
#!/bin/sh
# Build the fetch unit testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_fetch -o tb_fetch_sim || { echo "Build failed"; exit 1; }

out=$(./obj_dir/tb_fetch_sim 2>&1)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qF '** PASS **' \
    && echo "Simulation finished cleanly" \
    || { echo "Simulation reported errors"; exit 1; }

//--- tests/tb_fetch.sv
/* Testbench for the fetch unit with random stall and redirect traffic,
   a line memory model and a reference PC model */
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*, cache_pkg::*;
();

    localparam int TB_SETS     = 16;
    localparam int WAIT_LIMIT  = 200;    // Cycles per wait
    localparam int NUM_FETCHES = 2000;
    localparam logic [INSTR_W-1:0] WORD_KEY = 16'h5A3C;

    logic               clk;
    logic               rst;
    logic               stall;
    logic               redirect;
    logic               redirect_ret;
    logic [ADDR_W-1:0]  redirect_target;
    logic               mem_valid;
    logic [LINE_W-1:0]  mem_line;
    logic [ADDR_W-1:0]  pc;
    logic [INSTR_W-1:0] instr;
    logic               instr_valid;
    logic               mem_req;
    logic [ADDR_W-1:0]  mem_addr;

    // Scoreboard state
    int                errors;
    int                fetches;
    int                req_count;
    int                cycles;
    logic [31:0]       lcg_state;
    logic [ADDR_W-1:0] exp_pc;          // PC of the next valid fetch
    logic              branch_pending;
    logic              ret_check;
    logic [ADDR_W-1:0] ret_target;
    logic              hold_check;
    logic [ADDR_W-1:0] hold_pc;
    logic              random_on;
    logic              seen_valid;
    logic              seen_req;
    logic              timed_out;

    // Memory side
    logic              mem_busy;
    int                mem_cnt;         // Cycles left until mem_valid
    logic [LINE_W-1:0] mem_buf;

    // Cache contents as the model sees them
    logic              model_valid [TB_SETS];
    int                model_tag   [TB_SETS];

    fetch_unit #(
        .SETS (TB_SETS)
    ) fetch_unit_i (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .redirect        (redirect),
        .redirect_ret    (redirect_ret),
        .redirect_target (redirect_target),
        .mem_valid       (mem_valid),
        .mem_line        (mem_line),
        .pc              (pc),
        .instr           (instr),
        .instr_valid     (instr_valid),
        .mem_req         (mem_req),
        .mem_addr        (mem_addr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;        // 20 ns period
    end

    function automatic logic [15:0] rand_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // Four words from the aligned base, lowest address in the lowest bits
    function automatic logic [LINE_W-1:0] build_line(input logic [ADDR_W-1:0] base);
        logic [LINE_W-1:0] line;
        logic [ADDR_W-1:0] a;
        int                w;
        line = '0;
        for (w = 0; w < LINE_WORDS; w++) begin
            a = base + ADDR_W'(w);
            line[w*INSTR_W +: INSTR_W] = a ^ WORD_KEY;
        end
        return line;
    endfunction

    // Direct mapped lookup in the model
    function automatic logic line_resident(input logic [ADDR_W-1:0] addr);
        int line;
        line = int'(addr) / LINE_WORDS;
        return model_valid[line % TB_SETS] && (model_tag[line % TB_SETS] == line / TB_SETS);
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // Outputs are settled at the falling edge
    task automatic sample_outputs();
        int line;
        seen_valid = instr_valid;
        seen_req   = mem_req;
        if (cycles == 0) begin
            check_equal(pc, 0, "pc after reset");
            check_equal(instr_valid, 0, "instr_valid after reset");
        end
        cycles++;
        if (ret_check) begin
            check_equal(pc, ret_target, "pc after return");
            ret_check = 1'b0;
        end
        if (hold_check) begin
            check_equal(pc, hold_pc, "pc held by stall");
            hold_check = 1'b0;
        end
        if (stall) check_equal(instr_valid, 0, "instr_valid during stall");
        if (instr_valid) begin
            check_equal(pc, exp_pc, "fetch pc");
            check_equal(instr, exp_pc ^ WORD_KEY, "instruction word");
            check_equal(line_resident(pc), 1, "fetched line resident");
            exp_pc = exp_pc + 16'd1;
            branch_pending = 1'b0;      // Target reached
            fetches++;
        end
        if (mem_req) begin
            check_equal(line_resident(mem_addr), 0, "request for a resident line");
            line = int'(mem_addr) / LINE_WORDS;
            model_valid[line % TB_SETS] = 1'b1;
            model_tag[line % TB_SETS]   = line / TB_SETS;
            mem_buf  = build_line(mem_addr);
            mem_cnt  = 1 + int'(rand_next() % 16'd6);   // 1 to 6 cycles
            mem_busy = 1'b1;
            req_count++;
        end
        // Parked branch may legally move the PC under stall
        if (stall && !redirect && !branch_pending) begin
            hold_check = 1'b1;
            hold_pc    = pc;
        end
        if (redirect) begin
            exp_pc = redirect_target;
            if (redirect_ret) begin
                ret_check      = 1'b1;
                ret_target     = redirect_target;
                branch_pending = 1'b0;  // Return drops the parked branch
            end else begin
                branch_pending = 1'b1;
            end
        end
    endtask

    task automatic drive_inputs();
        mem_valid <= 1'b0;
        if (mem_busy) begin
            mem_cnt--;
            if (mem_cnt == 0) begin
                mem_valid <= 1'b1;
                mem_line  <= mem_buf;
                mem_busy  = 1'b0;
            end
        end
        if (random_on) begin
            stall <= (rand_next() % 16'd8) == 0;
            if ((rand_next() % 16'd30) == 0) begin
                redirect        <= 1'b1;
                redirect_ret    <= (rand_next() % 16'd4) == 0;  // A quarter are returns
                redirect_target <= rand_next() % 16'd256;
            end else begin
                redirect     <= 1'b0;
                redirect_ret <= 1'b0;
            end
        end else begin
            stall        <= 1'b0;
            redirect     <= 1'b0;
            redirect_ret <= 1'b0;
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        sample_outputs();
        @(posedge clk);
        drive_inputs();
    endtask

    task automatic wait_for_req();
        int n;
        n = 0;
        do begin
            step_cycle();
            n++;
        end while (!seen_req && n < WAIT_LIMIT);
        if (!seen_req) begin
            $display("Timeout: no memory request within %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_fetch();
        int n;
        n = 0;
        do begin
            step_cycle();
            n++;
        end while (!seen_valid && n < WAIT_LIMIT);
        if (!seen_valid) begin
            $display("Timeout: no valid instruction within %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        rst             = 1'b1;
        stall           = 1'b0;
        redirect        = 1'b0;
        redirect_ret    = 1'b0;
        redirect_target = '0;
        mem_valid       = 1'b0;
        mem_line        = '0;
        errors          = 0;
        fetches         = 0;
        req_count       = 0;
        cycles          = 0;
        lcg_state       = 32'd43;
        exp_pc          = '0;
        branch_pending  = 1'b0;
        ret_check       = 1'b0;
        ret_target      = '0;
        hold_check      = 1'b0;
        hold_pc         = '0;
        random_on       = 1'b0;
        seen_valid      = 1'b0;
        seen_req        = 1'b0;
        timed_out       = 1'b0;
        mem_busy        = 1'b0;
        mem_cnt         = 0;
        mem_buf         = '0;
        for (int s = 0; s < TB_SETS; s++) begin
            model_valid[s] = 1'b0;
            model_tag[s]   = 0;
        end

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Cold cache, first fetch at address 0 after one refill
        wait_for_req();
        if (!timed_out) begin
            wait_for_fetch();
        end

        random_on = 1'b1;
        for (int i = 0; i < NUM_FETCHES && !timed_out; i++) begin
            wait_for_fetch();
        end

        // Quiet tail, fetch must still flow
        random_on = 1'b0;
        for (int i = 0; i < 4 && !timed_out; i++) begin
            wait_for_fetch();
        end

        $display("Errors: %0d, fetches: %0d, memory requests: %0d",
                 errors, fetches, req_count);
        if (errors == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verilog/cache_pkg.sv
/* Instruction cache line geometry and the states of the line refill FSM */
package cache_pkg;

    // Four 16-bit words per line
    localparam int LINE_WORDS = 4;

    // Word offset bits inside a line
    localparam int OFFSET_W = $clog2(LINE_WORDS);

    // Whole line arrives in one beat
    localparam int LINE_W = 64;

    // Refill FSM
    typedef enum logic [1:0] {
        CS_LOOKUP  = 2'd0,  // Tag compare on the fetch address
        CS_REQUEST = 2'd1,  // One-cycle memory request
        CS_REFILL  = 2'd2   // Wait for mem_valid
    } cache_state_t;

    // Lowest word address sits in the lowest bits of the line
    // Line address on the bus is word aligned with offset bits zero

endpackage

//--- verilog/fetch_pkg.sv
/* Fetch side widths and the kind tag of a pending PC redirect */
package fetch_pkg;

    // Word-addressed PC with one instruction per word
    localparam int ADDR_W  = 16;
    localparam int INSTR_W = 16;

    // What the redirect latch is holding
    typedef enum logic [1:0] {
        REDIR_NONE   = 2'd0,    // Nothing parked
        REDIR_BRANCH = 2'd1,    // Taken branch waiting for cache_ready
        REDIR_RETURN = 2'd2     // Return target, goes straight to the PC
    } redirect_kind_t;

    // A return never waits in the latch
    // Only REDIR_BRANCH is ever parked
    // REDIR_RETURN marks the strobe cycle in the PC select

endpackage

//--- verilog/fetch_unit.sv
/* Instruction fetch top level holding the program counter and the
   next-PC select around the redirect latch and the instruction cache */
`timescale 1ns/1ps

module fetch_unit
    import fetch_pkg::*, cache_pkg::*;
#(
    parameter int SETS = 16                     // Cache lines
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,           // Downstream data hazard
    input  logic               redirect,        // One-cycle strobe
    input  logic               redirect_ret,    // Sampled with redirect
    input  logic [ADDR_W-1:0]  redirect_target,
    input  logic               mem_valid,
    input  logic [LINE_W-1:0]  mem_line,
    output logic [ADDR_W-1:0]  pc,
    output logic [INSTR_W-1:0] instr,
    output logic               instr_valid,
    output logic               mem_req,
    output logic [ADDR_W-1:0]  mem_addr
);

    // Redirect latch side
    logic              take_redirect;
    logic [ADDR_W-1:0] take_target;
    redirect_kind_t    pending_kind;

    // Cache side
    logic               cache_ready;
    logic [INSTR_W-1:0] cache_word;

    // PC select
    redirect_kind_t    redir_kind;
    logic              fetch_ok;
    logic [ADDR_W-1:0] pc_next;

    redirect_latch redirect_latch_i (
        .clk             (clk),
        .rst             (rst),
        .redirect        (redirect),
        .redirect_ret    (redirect_ret),
        .redirect_target (redirect_target),
        .cache_ready     (cache_ready),
        .take_redirect   (take_redirect),
        .take_target     (take_target),
        .pending_kind    (pending_kind)
    );

    icache_ctrl #(
        .SETS (SETS)
    ) icache_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .addr        (pc),
        .mem_valid   (mem_valid),
        .mem_line    (mem_line),
        .cache_ready (cache_ready),
        .cache_word  (cache_word),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr)
    );

    // Which redirect acts on this edge, return first
    always_comb begin
        if (redirect && redirect_ret) begin
            redir_kind = REDIR_RETURN;
        end else if (take_redirect) begin
            redir_kind = REDIR_BRANCH;
        end else begin
            redir_kind = REDIR_NONE;
        end
    end

    // A fetch counts only on a hit with no stall and no redirect in play
    // Word under a parked branch is wrong path
    assign fetch_ok = cache_ready && !stall
                      && (pending_kind == REDIR_NONE)
                      && (redir_kind != REDIR_RETURN);

    // Next PC
    always_comb begin
        pc_next = pc;                           // Hold by default
        case (redir_kind)
            REDIR_RETURN: pc_next = redirect_target;
            REDIR_BRANCH: pc_next = take_target;
            default: begin
                if (fetch_ok) begin
                    pc_next = pc + 1'b1;        // Sequential
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign instr       = cache_word;
    assign instr_valid = fetch_ok;

    // Stall freezes the PC unless a redirect acts
    a_stall_holds_pc: assert property (
        @(posedge clk) disable iff (rst)
        stall && !(redirect && redirect_ret) && !take_redirect |=> $stable(pc)
    ) else $error("fetch_unit moved the PC during a stall");

endmodule

//--- verilog/icache_ctrl.sv
/* Direct-mapped read-only instruction cache with tag compare on the
   fetch address and whole-line refill from memory on a miss */
`timescale 1ns/1ps

module icache_ctrl
    import fetch_pkg::*, cache_pkg::*;
#(
    parameter int SETS = 16                 // Number of lines, power of two
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [ADDR_W-1:0]  addr,        // Current PC
    input  logic               mem_valid,   // Refill data strobe
    input  logic [LINE_W-1:0]  mem_line,
    output logic               cache_ready, // Hit in lookup state
    output logic [INSTR_W-1:0] cache_word,
    output logic               mem_req,     // One pulse per miss
    output logic [ADDR_W-1:0]  mem_addr     // Line aligned word address
);

    localparam int IDX_W       = $clog2(SETS);
    localparam int TAG_W       = ADDR_W - IDX_W - OFFSET_W;
    localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

    cache_state_t state;
    cache_state_t state_next;

    // Fetch address split
    logic [OFFSET_W-1:0] word_sel;
    logic [IDX_W-1:0]    idx;
    logic [TAG_W-1:0]    tag;

    // Line storage
    logic [SETS-1:0]     valid_q;
    logic [TAG_W-1:0]    tag_q  [SETS];
    logic [LINE_W-1:0]   data_q [SETS];

    // Miss bookkeeping
    logic [LINE_ADDR_W-1:0] miss_line;
    logic [IDX_W-1:0]       miss_idx;
    logic [TAG_W-1:0]       miss_tag;

    logic              hit;
    logic              refill_done;
    logic [LINE_W-1:0] hit_line;

    assign word_sel = addr[OFFSET_W-1:0];
    assign idx      = addr[OFFSET_W +: IDX_W];
    assign tag      = addr[ADDR_W-1 -: TAG_W];

    // Combinational tag compare
    assign hit = valid_q[idx] && (tag_q[idx] == tag);

    // Word select inside the indexed line
    assign hit_line   = data_q[idx];
    assign cache_word = hit_line[word_sel*INSTR_W +: INSTR_W];

    // Only the lookup state answers the PC
    assign cache_ready = (state == CS_LOOKUP) && hit;

    assign miss_idx = miss_line[IDX_W-1:0];
    assign miss_tag = miss_line[LINE_ADDR_W-1 -: TAG_W];

    assign refill_done = (state == CS_REFILL) && mem_valid;

    // Memory side
    assign mem_req  = (state == CS_REQUEST);
    assign mem_addr = {miss_line, {OFFSET_W{1'b0}}};

    // Refill FSM
    always_comb begin
        state_next = state;
        case (state)
            CS_LOOKUP: begin
                if (!hit) begin
                    state_next = CS_REQUEST;
                end
            end
            CS_REQUEST: begin
                state_next = CS_REFILL;     // Request lasts one cycle
            end
            CS_REFILL: begin
                if (mem_valid) begin
                    state_next = CS_LOOKUP; // Lookup repeats and hits
                end
            end
            default: begin
                state_next = CS_LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CS_LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    // Freeze the missing line address until the refill lands
    // PC may move on a return meanwhile
    always_ff @(posedge clk) begin
        if (state == CS_LOOKUP && !hit) begin
            miss_line <= addr[ADDR_W-1:OFFSET_W];
        end
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;                  // All lines invalid
        end else if (refill_done) begin
            valid_q[miss_idx] <= 1'b1;
        end
    end

    // Tag and data arrays written on the mem_valid edge
    always_ff @(posedge clk) begin
        if (refill_done) begin
            data_q[miss_idx] <= mem_line;
            tag_q[miss_idx]  <= miss_tag;
        end
    end

    // Request only from CS_REQUEST
    a_req_state: assert property (
        @(posedge clk) disable iff (rst)
        mem_req |-> state == CS_REQUEST
    ) else $error("icache_ctrl raised mem_req outside CS_REQUEST");

    // Memory answers only while a refill is outstanding
    a_valid_refill: assert property (
        @(posedge clk) disable iff (rst)
        mem_valid |-> state == CS_REFILL
    ) else $error("icache_ctrl saw mem_valid with no refill pending");

endmodule

//--- verilog/redirect_latch.sv
/* Branch redirect latch that parks a taken branch target until
   the instruction cache can take a new fetch address */
`timescale 1ns/1ps

module redirect_latch
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              redirect,         // One-cycle strobe
    input  logic              redirect_ret,     // Marks the strobe as a return
    input  logic [ADDR_W-1:0] redirect_target,
    input  logic              cache_ready,      // Lookup hit this cycle
    output logic              take_redirect,    // Release pulse to the PC select
    output logic [ADDR_W-1:0] take_target,
    output redirect_kind_t    pending_kind
);

    logic branch_strobe;
    logic return_strobe;

    assign branch_strobe = redirect & ~redirect_ret;
    assign return_strobe = redirect & redirect_ret;

    // Release only on a hit so a refill in flight keeps the branch parked
    assign take_redirect = (pending_kind == REDIR_BRANCH) & cache_ready;

    // Pending state
    always_ff @(posedge clk) begin
        if (rst) begin
            pending_kind <= REDIR_NONE;
        end else if (branch_strobe) begin
            pending_kind <= REDIR_BRANCH;   // Newer branch replaces older one
        end else if (return_strobe) begin
            pending_kind <= REDIR_NONE;     // Return wins over a parked branch
        end else if (take_redirect) begin
            pending_kind <= REDIR_NONE;     // Released this edge
        end
    end

    // Target word
    // A strobe on the release edge overwrites after the PC has sampled
    always_ff @(posedge clk) begin
        if (branch_strobe) begin
            take_target <= redirect_target;
        end
    end

    // Release comes only from a parked branch
    a_take_needs_pending: assert property (
        @(posedge clk) disable iff (rst)
        take_redirect |-> pending_kind != REDIR_NONE
    ) else $error("redirect_latch released with nothing pending");

endmodule
